/* verilog/range_pad_pkg.sv */
package range_pad_pkg;

    // ========================================
    // widths
    // ========================================

    // adc sample width, signed two's complement
    parameter int SAMPLE_W = 16;

    // ========================================
    // data types
    // ========================================

    // one digitised range sample
    typedef logic [SAMPLE_W-1:0] sample_t;

    // range bins per pulse, also wide enough for nfft
    typedef logic [14:0] length_t;

    // point index inside one fft frame
    typedef logic [14:0] bin_t;

    // ========================================
    // reader fsm
    // ========================================

    // one-hot, one state per phase of the frame
    typedef enum logic [3:0] {
        st_idle    = 4'b0001,
        st_readout = 4'b0010,
        st_zero    = 4'b0100,
        st_finish  = 4'b1000
    } reader_state_t;

endpackage

/* verilog/sample_fifo.sv */
`timescale 1ns/10ps

module sample_fifo
    import range_pad_pkg::*;
#(
    parameter int fifo_depth_log2 = 11
)
(
    input  logic    clk,
    input  logic    rst,
    // producer side
    input  logic    sample_valid,
    input  sample_t sample_data,
    // reader side
    input  logic    rd_en,
    output sample_t rd_data,
    output logic    empty,
    // sticky error flags
    output logic    overflow,
    output logic    underflow
);

    localparam int depth = 2 ** fifo_depth_log2;

    // ========================================
    // storage and pointers
    // ========================================

    sample_t mem [depth];

    // extra msb is the wrap bit
    logic [fifo_depth_log2:0] wr_ptr;
    logic [fifo_depth_log2:0] rd_ptr;

    logic full;
    logic wr_fire;
    logic rd_fire;

    // same address, different lap
    assign full = (wr_ptr[fifo_depth_log2] != rd_ptr[fifo_depth_log2]) &&
                  (wr_ptr[fifo_depth_log2-1:0] == rd_ptr[fifo_depth_log2-1:0]);

    // same address, same lap
    assign empty = (wr_ptr == rd_ptr);

    // only accepted transfers move the pointers
    assign wr_fire = sample_valid && !full;
    assign rd_fire = rd_en && !empty;

    // ========================================
    // pointer update
    // ========================================

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (wr_fire)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd_fire)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // ========================================
    // data path
    // ========================================

    // write port
    always_ff @(posedge clk)
    begin
        if (wr_fire)
            mem[wr_ptr[fifo_depth_log2-1:0]] <= sample_data;
    end

    // read register, holds last word on an empty pop
    always_ff @(posedge clk)
    begin
        if (rd_fire)
            rd_data <= mem[rd_ptr[fifo_depth_log2-1:0]];
    end

    // ========================================
    // error flags
    // ========================================

    // set on first bad access, cleared only by reset
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            overflow  <= 1'b0;
            underflow <= 1'b0;
        end
        else
        begin
            // write dropped while full
            if (sample_valid && full)
                overflow <= 1'b1;
            // pop requested with nothing stored
            if (rd_en && empty)
                underflow <= 1'b1;
        end
    end

endmodule

/* verilog/zero_pad_reader.sv */
`timescale 1ns/10ps

module zero_pad_reader
    import range_pad_pkg::*;
#(
    parameter int nfft = 1024
)
(
    input  logic    clk,
    input  logic    rst,
    // fifo status
    input  logic    empty,
    // range gate length, 1 to nfft, stable during a frame
    input  length_t range_length,
    // slot strobes, registered
    output logic    rd_en,
    output logic    zero_en
);

    // index of the final point in a frame
    localparam bin_t last_bin = bin_t'(nfft - 1);

    reader_state_t state;
    reader_state_t next_state;

    // slot index within the current frame
    bin_t bin_cnt;

    // index of the final fifo read
    length_t last_read_bin;

    logic frame_done;

    assign last_read_bin = range_length - length_t'(1);

    // last slot of the frame, in either phase
    assign frame_done = ((state == st_readout) || (state == st_zero)) &&
                        (bin_cnt == last_bin);

    // ========================================
    // state register
    // ========================================

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            state <= st_idle;
        else
            state <= next_state;
    end

    // ========================================
    // next state
    // ========================================

    always_comb
    begin
        next_state = state;
        case (state)
            st_idle:
            begin
                // start on first buffered sample
                if (!empty)
                    next_state = st_readout;
            end

            st_readout:
            begin
                // full-length gate skips the zero phase
                // last two pops still in flight, so empty says nothing yet
                if (frame_done)
                    next_state = st_finish;
                else if (bin_cnt == last_read_bin)
                    next_state = st_zero;
            end

            st_zero:
            begin
                // chain straight into the next pulse if data waits
                // a read still in flight keeps empty low
                if (frame_done)
                    next_state = (empty || rd_en) ? st_finish : st_readout;
            end

            st_finish:
            begin
                next_state = st_idle;
            end

            default:
            begin
                next_state = st_idle;
            end
        endcase
    end

    // ========================================
    // bin counter
    // ========================================

    // runs only inside a frame, cleared otherwise
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            bin_cnt <= '0;
        else if ((state != st_readout) && (state != st_zero))
            bin_cnt <= '0;
        else if (bin_cnt == last_bin)
            bin_cnt <= '0;
        else
            bin_cnt <= bin_cnt + 1'b1;
    end

    // ========================================
    // output decode
    // ========================================

    // one cycle behind the state
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            rd_en   <= 1'b0;
            zero_en <= 1'b0;
        end
        else
        begin
            rd_en   <= (state == st_readout);
            zero_en <= (state == st_zero);
        end
    end

endmodule

/* verilog/frame_formatter.sv */
`timescale 1ns/10ps

module frame_formatter
    import range_pad_pkg::*;
#(
    parameter int nfft = 1024
)
(
    input  logic    clk,
    input  logic    rst,
    // slot strobes from the reader
    input  logic    rd_en,
    input  logic    zero_en,
    // fifo read register, valid one cycle after rd_en
    input  sample_t rd_data,
    // frame stream
    output logic    out_valid,
    output sample_t out_data,
    output logic    out_first,
    output logic    out_last
);

    localparam bin_t last_bin = bin_t'(nfft - 1);

    // slot type aligned with rd_data
    logic rd_q;
    logic zero_q;
    logic slot_q;

    // position of the next emitted point
    bin_t out_idx;

    assign slot_q = rd_q || zero_q;

    // ========================================
    // stage 1: align slot with fifo data
    // ========================================

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            rd_q   <= 1'b0;
            zero_q <= 1'b0;
        end
        else
        begin
            rd_q   <= rd_en;
            zero_q <= zero_en;
        end
    end

    // ========================================
    // stage 2: output register
    // ========================================

    // zero slots and idle cycles both give zero
    always_ff @(posedge clk)
    begin
        out_data <= rd_q ? rd_data : '0;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            out_valid <= 1'b0;
            out_first <= 1'b0;
            out_last  <= 1'b0;
            out_idx   <= '0;
        end
        else
        begin
            out_valid <= slot_q;
            // frame markers only on real points
            out_first <= slot_q && (out_idx == '0);
            out_last  <= slot_q && (out_idx == last_bin);
            // wrap at nfft
            if (slot_q)
                out_idx <= (out_idx == last_bin) ? '0 : out_idx + 1'b1;
        end
    end

endmodule

/* verilog/range_pad_top.sv */
`timescale 1ns/10ps

module range_pad_top
    import range_pad_pkg::*;
#(
    parameter int nfft            = 1024,
    parameter int fifo_depth_log2 = 11
)
(
    input  logic    clk,
    input  logic    rst,
    // adc side
    input  logic    sample_valid,
    input  sample_t sample_data,
    input  length_t range_length,
    // fft side
    output logic    out_valid,
    output sample_t out_data,
    output logic    out_first,
    output logic    out_last,
    // sticky status
    output logic    overflow,
    output logic    underflow
);

    // ========================================
    // inter-stage nets
    // ========================================

    logic    empty;
    logic    rd_en;
    logic    zero_en;
    sample_t rd_data;

    // buffer for one or more pulses
    sample_fifo #(
        .fifo_depth_log2 (fifo_depth_log2)
    ) sample_fifo_i (
        .clk          (clk),
        .rst          (rst),
        .sample_valid (sample_valid),
        .sample_data  (sample_data),
        .rd_en        (rd_en),
        .rd_data      (rd_data),
        .empty        (empty),
        .overflow     (overflow),
        .underflow    (underflow)
    );

    // read and zero slot sequencing
    zero_pad_reader #(
        .nfft (nfft)
    ) zero_pad_reader_i (
        .clk          (clk),
        .rst          (rst),
        .empty        (empty),
        .range_length (range_length),
        .rd_en        (rd_en),
        .zero_en      (zero_en)
    );

    // point select and frame marks
    frame_formatter #(
        .nfft (nfft)
    ) frame_formatter_i (
        .clk       (clk),
        .rst       (rst),
        .rd_en     (rd_en),
        .zero_en   (zero_en),
        .rd_data   (rd_data),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_first (out_first),
        .out_last  (out_last)
    );

endmodule

/* dv/range_pad_tb.sv */
`timescale 1ns/10ps

module range_pad_tb
    import range_pad_pkg::*;
();

    localparam int nfft            = 16;
    localparam int fifo_depth_log2 = 5;
    // frames issued over all tests, overflow burst keeps 35 words
    localparam int test_frames     = 1 + 3 + 2 + 35 + 1;
    localparam int watchdog_cycles = test_frames * (nfft + 10) + 400;

    logic    clk;
    logic    rst;
    logic    sample_valid;
    sample_t sample_data;
    length_t range_length;
    logic    out_valid;
    sample_t out_data;
    logic    out_first;
    logic    out_last;
    logic    overflow;
    logic    underflow;

    // expected samples, in write order
    sample_t     model_q [$];
    // collected output points
    sample_t     out_data_q [$];
    logic        out_first_q [$];
    logic        out_last_q [$];
    int          out_cyc_q [$];
    logic [31:0] rng_state;
    int          cyc;
    int          checks;
    int          errors;

    range_pad_top #(
        .nfft            (nfft),
        .fifo_depth_log2 (fifo_depth_log2)
    ) range_pad_top_i (
        .clk          (clk),
        .rst          (rst),
        .sample_valid (sample_valid),
        .sample_data  (sample_data),
        .range_length (range_length),
        .out_valid    (out_valid),
        .out_data     (out_data),
        .out_first    (out_first),
        .out_last     (out_last),
        .overflow     (overflow),
        .underflow    (underflow)
    );

    // ========================================
    // clock, cycle count, monitor
    // ========================================

    always #50 clk = ~clk;

    always @(posedge clk)
        cyc <= cyc + 1;

    // outputs settle after the rising edge
    always @(negedge clk)
    begin
        if (out_valid)
        begin
            out_data_q.push_back(out_data);
            out_first_q.push_back(out_first);
            out_last_q.push_back(out_last);
            out_cyc_q.push_back(cyc);
        end
    end

    // ========================================
    // helpers and checks
    // ========================================

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_sample(input sample_t got, input sample_t exp, input string msg);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Fail at %0t: %s, got %h expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic check_index(input bin_t got, input bin_t exp, input string msg);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Fail at %0t: %s, got %0d expected %0d", $time, msg, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string msg);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Fail at %0t: %s, got %b expected %b", $time, msg, got, exp);
        end
    endtask

    task automatic set_length(input int n);
        @(negedge clk);
        range_length = length_t'(n);
    endtask

    // one write per cycle, random data
    task automatic write_pulse(input int n);
        for (int k = 0; k < n; k++)
        begin
            @(negedge clk);
            rng_state    = xorshift32(rng_state);
            sample_valid = 1'b1;
            sample_data  = rng_state[SAMPLE_W-1:0];
            model_q.push_back(rng_state[SAMPLE_W-1:0]);
        end
        @(negedge clk);
        sample_valid = 1'b0;
    endtask

    // watchdog bounds this wait
    task automatic wait_points(input int n);
        while (out_data_q.size() < n)
            @(posedge clk);
    endtask

    // frames must be chained, gate samples then zeros
    task automatic check_frames(input int nframes, input int rlen);
        sample_t exp;
        int      prev_cyc;
        wait_points(nframes * nfft);
        prev_cyc = out_cyc_q[0] - 1;
        for (int f = 0; f < nframes; f++)
        begin
            for (int i = 0; i < nfft; i++)
            begin
                if (i < rlen)
                    exp = model_q.pop_front();
                else
                    exp = '0;
                check_sample(out_data_q[0], exp, $sformatf("frame %0d point %0d", f, i));
                check_flag(out_first_q[0], i == 0, $sformatf("first flag, point %0d", i));
                check_flag(out_last_q[0], i == nfft - 1, $sformatf("last flag, point %0d", i));
                check_flag(out_cyc_q[0] == prev_cyc + 1, 1'b1, "out_valid gap");
                prev_cyc = out_cyc_q[0];
                out_data_q.delete(0);
                out_first_q.delete(0);
                out_last_q.delete(0);
                out_cyc_q.delete(0);
            end
        end
    endtask

    task automatic check_quiet(input int cycles);
        repeat (cycles) @(posedge clk);
        check_index(bin_t'(out_data_q.size()), '0, "points after the last frame");
    endtask

    // ========================================
    // directed tests
    // ========================================

    task automatic test_idle();
        for (int k = 0; k < 50; k++)
        begin
            @(negedge clk);
            check_flag(out_valid, 1'b0, "out_valid while idle");
            check_flag(overflow, 1'b0, "overflow while idle");
            check_flag(underflow, 1'b0, "underflow while idle");
        end
    endtask

    task automatic test_single();
        set_length(5);
        write_pulse(5);
        check_frames(1, 5);
        check_quiet(20);
    endtask

    task automatic test_back_to_back();
        set_length(5);
        repeat (3) write_pulse(5);
        check_frames(3, 5);
        check_quiet(20);
    endtask

    task automatic test_extremes();
        set_length(1);
        write_pulse(1);
        check_frames(1, 1);
        check_quiet(20);
        set_length(nfft);
        write_pulse(nfft);
        check_frames(1, nfft);
        check_quiet(20);
        check_flag(overflow, 1'b0, "overflow after extremes");
        check_flag(underflow, 1'b0, "underflow after extremes");
    endtask

    // one pop per frame, so a steady burst fills the fifo
    task automatic test_overflow();
        int   occ;
        logic full;
        logic dropped;
        occ     = 0;
        dropped = 1'b0;
        set_length(1);
        for (int k = 0; k < 48; k++)
        begin
            @(negedge clk);
            // sticky from the edge of the first dropped write
            check_flag(overflow, dropped, $sformatf("overflow before write %0d", k));
            rng_state    = xorshift32(rng_state);
            sample_valid = 1'b1;
            sample_data  = rng_state[SAMPLE_W-1:0];
            // level before this edge, drop when full
            full = (occ == 2 ** fifo_depth_log2);
            if (full)
                dropped = 1'b1;
            if (!full)
                model_q.push_back(rng_state[SAMPLE_W-1:0]);
            occ = occ + (full ? 0 : 1);
            // pops land 3 edges after the first write, then once per frame
            if (k >= 3 && (k - 3) % nfft == 0)
                occ = occ - 1;
        end
        @(negedge clk);
        sample_valid = 1'b0;
        check_frames(model_q.size(), 1);
        check_quiet(20);
        check_flag(overflow, 1'b1, "overflow after burst");
        check_flag(underflow, 1'b0, "underflow after burst");
    endtask

    // short pulse
    task automatic test_underflow();
        sample_t stale;
        set_length(8);
        write_pulse(2);
        // empty pops repeat the word left in the read register
        stale = model_q[1];
        repeat (6) model_q.push_back(stale);
        check_frames(1, 8);
        check_quiet(20);
        check_flag(underflow, 1'b1, "underflow after short pulse");
    endtask

    // ========================================
    // run control
    // ========================================

    initial
    begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: run did not complete within %0d cycles", watchdog_cycles);
        $display("STATUS: FAIL");
        $finish;
    end

    initial
    begin
        clk          = 1'b0;
        rst          = 1'b1;
        sample_valid = 1'b0;
        sample_data  = '0;
        range_length = length_t'(5);
        rng_state    = 32'h3800_9c3e;
        cyc          = 0;
        checks       = 0;
        errors       = 0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        test_idle();
        test_single();
        test_back_to_back();
        test_extremes();
        test_overflow();
        test_underflow();
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* range_pad.f */
verilog/range_pad_pkg.sv
verilog/sample_fifo.sv
verilog/zero_pad_reader.sv
verilog/frame_formatter.sv
verilog/range_pad_top.sv
dv/range_pad_tb.sv

/* Makefile */
TOP := range_pad_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --timescale 1ns/10ps --top-module $(TOP) \
		-f range_pad.f -o sim
	@out=$$(./obj_dir/sim); echo "$$out"; \
		echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf obj_dir
